//--- hdl/rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int XLEN = 32;

    // major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // branch kinds in funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // the only CSR, written by csrw / csrwi
    localparam logic [11:0] CSR_TOHOST = 12'h51E;

    // addi x0, x0, 0
    localparam logic [31:0] NOP_INSTR = 32'h0000_0013;

    localparam logic [31:0] RESET_PC = 32'h0000_0000;

endpackage

//--- hdl/rv_ctrl_pkg.sv
package rv_ctrl_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        // lui passes the immediate through
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_sel_e;

    typedef enum logic [1:0] {WB_LOAD, WB_ALU, WB_PC4} wb_sel_e;

    // matches funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        MEM_BYTE = 2'b00,
        MEM_HALF = 2'b01,
        MEM_WORD = 2'b10
    } mem_size_e;

    localparam int IMEM_WORDS = 1024;
    localparam int DMEM_WORDS = 1024;

endpackage

//--- hdl/controller.sv
`timescale 1ns/1ns

module controller (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   run,
    input  logic [31:0]            instr_d,
    input  logic                   br_taken,
    output logic                   flush,
    output logic                   reg_we_w,
    output logic                   mem_we_x,
    output logic                   tohost_we_x,
    output logic                   fwd_a_d,
    output logic                   fwd_b_d,
    output logic                   fwd_a_x,
    output logic                   fwd_b_x,
    output logic                   a_sel_pc_x,
    output logic                   b_sel_imm_x,
    output logic                   csr_imm_x,
    output logic                   is_jump_x,
    output rv_ctrl_pkg::imm_sel_e  imm_sel,
    output rv_ctrl_pkg::alu_op_e   alu_op_x,
    output rv_ctrl_pkg::mem_size_e mem_size_x,
    output rv_ctrl_pkg::mem_size_e mem_size_w,
    output logic                   load_unsigned_w,
    output rv_ctrl_pkg::wb_sel_e   wb_sel_w,
    output logic [4:0]             rd_w
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    logic [6:0] opcode;
    logic [2:0] f3;
    logic       reg_we_d;
    logic       mem_we_d;
    logic       tohost_we_d;
    alu_op_e    alu_op_d;
    wb_sel_e    wb_sel_d;

    logic       reg_we_x;
    logic       is_branch_x;
    logic       f3_hi_x;
    wb_sel_e    wb_sel_x;
    logic [4:0] rd_x;
    logic [4:0] rs1_x;
    logic [4:0] rs2_x;

    assign opcode = instr_d[6:0];
    assign f3     = instr_d[14:12];

    assign reg_we_d = opcode inside {OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR,
                                     OPC_LOAD, OPC_OPIMM, OPC_OP};
    assign mem_we_d = (opcode == OPC_STORE);
    // csrrw / csrrwi only, other CSR ops are ignored
    assign tohost_we_d = (opcode == OPC_SYSTEM) && (instr_d[31:20] == CSR_TOHOST) &&
                         (f3[1:0] == 2'b01);

    always_comb begin
        case (opcode)
            OPC_LUI, OPC_AUIPC: imm_sel = IMM_U;
            OPC_JAL:            imm_sel = IMM_J;
            OPC_BRANCH:         imm_sel = IMM_B;
            OPC_STORE:          imm_sel = IMM_S;
            default:            imm_sel = IMM_I;
        endcase
    end

    always_comb begin
        case (opcode)
            OPC_LOAD:          wb_sel_d = WB_LOAD;
            OPC_JAL, OPC_JALR: wb_sel_d = WB_PC4;
            default:           wb_sel_d = WB_ALU;
        endcase
    end

    always_comb begin
        alu_op_d = ALU_ADD;
        if (opcode == OPC_LUI) begin
            alu_op_d = ALU_PASS_B;
        end else if (opcode == OPC_OP || opcode == OPC_OPIMM) begin
            case (f3)
                // sub only exists in the register form
                3'b000:  alu_op_d = (instr_d[30] && opcode == OPC_OP) ? ALU_SUB : ALU_ADD;
                3'b001:  alu_op_d = ALU_SLL;
                3'b010:  alu_op_d = ALU_SLT;
                3'b011:  alu_op_d = ALU_SLTU;
                3'b100:  alu_op_d = ALU_XOR;
                3'b101:  alu_op_d = instr_d[30] ? ALU_SRA : ALU_SRL;
                3'b110:  alu_op_d = ALU_OR;
                default: alu_op_d = ALU_AND;
            endcase
        end
    end

    // enables and redirect state
    always_ff @(posedge clk) begin
        if (rst) begin
            reg_we_x    <= 1'b0;
            mem_we_x    <= 1'b0;
            tohost_we_x <= 1'b0;
            is_jump_x   <= 1'b0;
            is_branch_x <= 1'b0;
            reg_we_w    <= 1'b0;
        end else begin
            reg_we_x    <= reg_we_d;
            mem_we_x    <= mem_we_d;
            tohost_we_x <= tohost_we_d;
            is_jump_x   <= opcode inside {OPC_JAL, OPC_JALR};
            is_branch_x <= (opcode == OPC_BRANCH);
            reg_we_w    <= reg_we_x;
        end
    end

    always_ff @(posedge clk) begin
        a_sel_pc_x      <= opcode inside {OPC_AUIPC, OPC_JAL, OPC_BRANCH};
        b_sel_imm_x     <= (opcode != OPC_OP);
        alu_op_x        <= alu_op_d;
        mem_size_x      <= mem_size_e'(f3[1:0]);
        f3_hi_x         <= f3[2];
        wb_sel_x        <= wb_sel_d;
        rd_x            <= instr_d[11:7];
        rs1_x           <= instr_d[19:15];
        rs2_x           <= instr_d[24:20];
        mem_size_w      <= mem_size_x;
        load_unsigned_w <= f3_hi_x;
        wb_sel_w        <= wb_sel_x;
        rd_w            <= rd_x;
    end

    // funct3[2] marks csrwi as well as unsigned loads
    assign csr_imm_x = f3_hi_x;

    // writeback feeds both earlier stages
    assign fwd_a_d = reg_we_w && (rd_w != 5'd0) && (rd_w == instr_d[19:15]);
    assign fwd_b_d = reg_we_w && (rd_w != 5'd0) && (rd_w == instr_d[24:20]);
    assign fwd_a_x = reg_we_w && (rd_w != 5'd0) && (rd_w == rs1_x);
    assign fwd_b_x = reg_we_w && (rd_w != 5'd0) && (rd_w == rs2_x);

    // also squashes decode while the core is stopped
    assign flush = !run || is_jump_x || (is_branch_x && br_taken);

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/1ns

module reg_file (
    input  logic                         clk,
    input  logic                         we,
    input  logic [4:0]                   ra1,
    input  logic [4:0]                   ra2,
    input  logic [4:0]                   wa,
    input  logic [rv_isa_pkg::XLEN-1:0] wd,
    output logic [rv_isa_pkg::XLEN-1:0] rd1,
    output logic [rv_isa_pkg::XLEN-1:0] rd2
);

    logic [rv_isa_pkg::XLEN-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (we && wa != 5'd0)
            regs[wa] <= wd;
    end

    // x0 reads as zero
    assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

endmodule

//--- hdl/imm_gen.sv
`timescale 1ns/1ns

module imm_gen (
    input  logic [31:7]           instr,
    input  rv_ctrl_pkg::imm_sel_e imm_sel,
    output logic [31:0]           imm
);
    import rv_ctrl_pkg::*;

    always_comb begin
        case (imm_sel)
            IMM_S:
                imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
            IMM_B:
                imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            IMM_U:
                imm = {instr[31:12], 12'd0};
            IMM_J:
                imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default:
                imm = {{21{instr[31]}}, instr[30:20]};
        endcase
    end

endmodule

//--- hdl/exec_unit.sv
`timescale 1ns/1ns

module exec_unit (
    input  logic [rv_isa_pkg::XLEN-1:0] op_a,
    input  logic [rv_isa_pkg::XLEN-1:0] op_b,
    input  logic [rv_isa_pkg::XLEN-1:0] rs1_val,
    input  logic [rv_isa_pkg::XLEN-1:0] rs2_val,
    input  rv_ctrl_pkg::alu_op_e        alu_op,
    input  logic [2:0]                  funct3,
    output logic [rv_isa_pkg::XLEN-1:0] result,
    output logic                        br_cond
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    logic [4:0] shamt;
    logic       eq;
    logic       lt;
    logic       ltu;

    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op)
            ALU_SUB:    result = op_a - op_b;
            ALU_AND:    result = op_a & op_b;
            ALU_OR:     result = op_a | op_b;
            ALU_XOR:    result = op_a ^ op_b;
            ALU_SLL:    result = op_a << shamt;
            ALU_SRL:    result = op_a >> shamt;
            ALU_SRA:    result = $signed(op_a) >>> shamt;
            ALU_SLT:    result = {31'd0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   result = {31'd0, op_a < op_b};
            ALU_PASS_B: result = op_b;
            default:    result = op_a + op_b;
        endcase
    end

    // comparator works on the register values, not the alu operands
    assign eq  = (rs1_val == rs2_val);
    assign lt  = $signed(rs1_val) < $signed(rs2_val);
    assign ltu = rs1_val < rs2_val;

    always_comb begin
        case (funct3)
            F3_BEQ:  br_cond = eq;
            F3_BNE:  br_cond = !eq;
            F3_BLT:  br_cond = lt;
            F3_BGE:  br_cond = !lt;
            F3_BLTU: br_cond = ltu;
            F3_BGEU: br_cond = !ltu;
            default: br_cond = 1'b0;
        endcase
    end

endmodule

//--- hdl/mem_align.sv
`timescale 1ns/1ns

module mem_align (
    input  rv_ctrl_pkg::mem_size_e size_x,
    input  logic [1:0]             offset_x,
    input  logic [31:0]            store_val,
    input  logic                   store_en,
    output logic [3:0]             byte_we,
    output logic [31:0]            store_word,
    input  rv_ctrl_pkg::mem_size_e size_w,
    input  logic [1:0]             offset_w,
    input  logic                   load_unsigned,
    input  logic [31:0]            load_word,
    output logic [31:0]            load_val
);
    import rv_ctrl_pkg::*;

    logic [3:0]  lanes;
    logic [31:0] shifted;

    // store data is replicated, byte enables pick the lane
    always_comb begin
        case (size_x)
            MEM_BYTE: begin
                store_word = {4{store_val[7:0]}};
                lanes      = 4'b0001 << offset_x;
            end
            MEM_HALF: begin
                store_word = {2{store_val[15:0]}};
                lanes      = 4'b0011 << {offset_x[1], 1'b0};
            end
            default: begin
                store_word = store_val;
                lanes      = 4'b1111;
            end
        endcase
    end

    assign byte_we = store_en ? lanes : 4'b0000;

    assign shifted = load_word >> {offset_w, 3'b000};

    always_comb begin
        case (size_w)
            MEM_BYTE: load_val = {{24{!load_unsigned && shifted[7]}}, shifted[7:0]};
            MEM_HALF: load_val = {{16{!load_unsigned && shifted[15]}}, shifted[15:0]};
            default:  load_val = load_word;
        endcase
    end

endmodule

//--- hdl/sync_ram.sv
`timescale 1ns/1ns

module sync_ram #(
    parameter int WORDS = 256
) (
    input  logic                     clk,
    input  logic [3:0]               we,
    input  logic [$clog2(WORDS)-1:0] waddr,
    input  logic [$clog2(WORDS)-1:0] raddr,
    input  logic [31:0]              wdata,
    output logic [31:0]              rdata
);

    logic [31:0] mem [WORDS];

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (we[i])
                mem[waddr][8*i +: 8] <= wdata[8*i +: 8];
        end
    end

    // read returns the old word on a same-address write
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

//--- hdl/riscv_core.sv
`timescale 1ns/1ns

module riscv_core (
    input  logic        clk,
    input  logic        rst,
    input  logic        run,
    input  logic        load_valid,
    output logic        load_ready,
    input  logic [9:0]  load_addr,
    input  logic [31:0] load_data,
    output logic        tohost_valid,
    output logic [31:0] tohost_data
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    // fetch / decode
    logic [31:0] pc;
    logic [31:0] next_pc;
    logic        run_q;
    logic [31:0] imem_rdata;
    logic [31:0] instr_d;
    logic [31:0] rd1;
    logic [31:0] rd2;
    logic [31:0] rs1_d;
    logic [31:0] rs2_d;
    logic [31:0] imm_d;

    // execute
    logic [31:0] pc_x;
    logic [31:0] rs1_val_x;
    logic [31:0] rs2_val_x;
    logic [31:0] imm_x;
    logic [2:0]  funct3_x;
    logic [4:0]  zimm_x;
    logic [31:0] rs1_fwd_x;
    logic [31:0] rs2_fwd_x;
    logic [31:0] alu_result;
    logic        br_taken;
    logic [3:0]  dmem_we;
    logic [31:0] store_word;

    // writeback
    logic [31:0] alu_w;
    logic [31:0] pc4_w;
    logic [31:0] dmem_rdata;
    logic [31:0] load_val;
    logic [31:0] wb_data;

    // controls
    logic        flush;
    logic        reg_we_w;
    logic        mem_we_x;
    logic        tohost_we_x;
    logic        fwd_a_d;
    logic        fwd_b_d;
    logic        fwd_a_x;
    logic        fwd_b_x;
    logic        a_sel_pc_x;
    logic        b_sel_imm_x;
    logic        csr_imm_x;
    imm_sel_e    imm_sel;
    alu_op_e     alu_op_x;
    mem_size_e   mem_size_x;
    mem_size_e   mem_size_w;
    logic        load_unsigned_w;
    wb_sel_e     wb_sel_w;
    logic [4:0]  rd_w;

    controller ctrl (
        .clk(clk), .rst(rst), .run(run_q),
        .instr_d(instr_d), .br_taken(br_taken),
        .flush(flush), .reg_we_w(reg_we_w), .mem_we_x(mem_we_x), .tohost_we_x(tohost_we_x),
        .fwd_a_d(fwd_a_d), .fwd_b_d(fwd_b_d), .fwd_a_x(fwd_a_x), .fwd_b_x(fwd_b_x),
        .a_sel_pc_x(a_sel_pc_x), .b_sel_imm_x(b_sel_imm_x), .csr_imm_x(csr_imm_x),
        .is_jump_x(), .imm_sel(imm_sel), .alu_op_x(alu_op_x),
        .mem_size_x(mem_size_x), .mem_size_w(mem_size_w),
        .load_unsigned_w(load_unsigned_w), .wb_sel_w(wb_sel_w), .rd_w(rd_w)
    );

    // imem is only written by the load port while stopped
    assign load_ready = !run;

    always_ff @(posedge clk) begin
        if (rst) begin
            run_q <= 1'b0;
            pc    <= RESET_PC;
        end else begin
            run_q <= run;
            pc    <= next_pc;
        end
    end

    // with run_q high a flush means execute redirects
    always_comb begin
        if (!run_q)
            next_pc = pc;
        else if (flush)
            next_pc = {alu_result[31:1], 1'b0};
        else
            next_pc = pc + 32'd4;
    end

    sync_ram #(.WORDS(IMEM_WORDS)) imem_ram (
        .clk(clk),
        .we({4{load_valid && load_ready}}),
        .waddr(load_addr),
        .raddr(next_pc[$clog2(IMEM_WORDS)+1:2]),
        .wdata(load_data),
        .rdata(imem_rdata)
    );

    assign instr_d = flush ? NOP_INSTR : imem_rdata;

    reg_file rf (
        .clk(clk), .we(reg_we_w),
        .ra1(instr_d[19:15]), .ra2(instr_d[24:20]), .wa(rd_w),
        .wd(wb_data), .rd1(rd1), .rd2(rd2)
    );

    imm_gen imm (.instr(instr_d[31:7]), .imm_sel(imm_sel), .imm(imm_d));

    assign rs1_d = fwd_a_d ? wb_data : rd1;
    assign rs2_d = fwd_b_d ? wb_data : rd2;

    always_ff @(posedge clk) begin
        pc_x      <= pc;
        rs1_val_x <= rs1_d;
        rs2_val_x <= rs2_d;
        imm_x     <= imm_d;
        funct3_x  <= instr_d[14:12];
        zimm_x    <= instr_d[19:15];
        alu_w     <= alu_result;
        pc4_w     <= pc_x + 32'd4;
    end

    assign rs1_fwd_x = fwd_a_x ? wb_data : rs1_val_x;
    assign rs2_fwd_x = fwd_b_x ? wb_data : rs2_val_x;

    exec_unit alu (
        .op_a(a_sel_pc_x ? pc_x : rs1_fwd_x),
        .op_b(b_sel_imm_x ? imm_x : rs2_fwd_x),
        .rs1_val(rs1_fwd_x), .rs2_val(rs2_fwd_x),
        .alu_op(alu_op_x), .funct3(funct3_x),
        .result(alu_result), .br_cond(br_taken)
    );

    mem_align align (
        .size_x(mem_size_x), .offset_x(alu_result[1:0]),
        .store_val(rs2_fwd_x), .store_en(mem_we_x),
        .byte_we(dmem_we), .store_word(store_word),
        .size_w(mem_size_w), .offset_w(alu_w[1:0]),
        .load_unsigned(load_unsigned_w), .load_word(dmem_rdata), .load_val(load_val)
    );

    sync_ram #(.WORDS(DMEM_WORDS)) dmem_ram (
        .clk(clk),
        .we(dmem_we),
        .waddr(alu_result[$clog2(DMEM_WORDS)+1:2]),
        .raddr(alu_result[$clog2(DMEM_WORDS)+1:2]),
        .wdata(store_word),
        .rdata(dmem_rdata)
    );

    always_comb begin
        case (wb_sel_w)
            WB_LOAD: wb_data = load_val;
            WB_PC4:  wb_data = pc4_w;
            default: wb_data = alu_w;
        endcase
    end

    // tohost leaves one cycle after execute
    always_ff @(posedge clk) begin
        if (rst)
            tohost_valid <= 1'b0;
        else
            tohost_valid <= tohost_we_x;
    end

    always_ff @(posedge clk) begin
        if (tohost_we_x)
            tohost_data <= csr_imm_x ? {27'd0, zimm_x} : rs1_fwd_x;
    end

endmodule

//--- test/tb_riscv_core.sv
`timescale 1ns/1ns

module tb_riscv_core;
    import rv_ctrl_pkg::*;

    localparam int STIM_DEPTH = 256;
    localparam int DRAIN_CYCLES = 30;
    // self-loop that ends the program
    localparam logic [31:0] JAL_SELF  = 32'h0000_006F;
    // csrwi tohost 1
    localparam logic [31:0] CSRWI_ONE = 32'h51E0_D073;

    logic        clk;
    logic        rst;
    logic        run;
    logic        load_valid;
    logic        load_ready;
    logic [9:0]  load_addr;
    logic [31:0] load_data;
    logic        tohost_valid;
    logic [31:0] tohost_data;

    logic [31:0] stim [STIM_DEPTH];
    logic [31:0] observed [$];
    logic [31:0] rng_state;
    int          word_count;
    int          exp_count;
    int          exp_base;
    int          cycles;
    int          cycle_limit;
    int          errors;
    int          tests_run;
    int          tests_failed;

    riscv_core riscv_core_inst (
        .clk(clk),
        .rst(rst),
        .run(run),
        .load_valid(load_valid),
        .load_ready(load_ready),
        .load_addr(load_addr),
        .load_data(load_data),
        .tohost_valid(tohost_valid),
        .tohost_data(tohost_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    // tohost writes, sampled mid-cycle
    always @(negedge clk) begin
        if (rst === 1'b0 && tohost_valid === 1'b1)
            observed.push_back(tohost_data);
    end

    initial begin
        wait (cycle_limit > 0);
        while (cycles < cycle_limit)
            @(negedge clk);
        $display("timeout: no result after %0d cycles, %0d of %0d tohost writes seen",
                 cycle_limit, observed.size(), exp_count);
        $display("=== FAIL ===");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAIL %0t ns: %s, got %08h, expected %08h", $time, what, actual, expected);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d mismatches", name, errors - errors_before);
        end
    endtask

    // one word per handshake, random idle gaps in between
    task automatic load_program();
        int gap;
        for (int i = 0; i < word_count; i++) begin
            rng_state = xorshift32(rng_state);
            gap = rng_state % 4;
            repeat (gap) begin
                @(posedge clk);
                load_valid <= 1'b0;
            end
            @(posedge clk);
            load_valid <= 1'b1;
            load_addr  <= 10'(i);
            load_data  <= stim[i + 1];
            @(negedge clk);
            check_equal(load_ready, 1'b1, "load_ready while stopped");
            while (!load_ready)
                @(negedge clk);
        end
        @(posedge clk);
        load_valid <= 1'b0;
    endtask

    initial begin
        int   errors_before;
        int   loop_idx;
        logic stim_ok;
        rst         = 1'b1;
        run         = 1'b0;
        load_valid  = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        rng_state   = 32'h78f2;
        cycles      = 0;
        cycle_limit = 0;
        errors      = 0;
        tests_run   = 0;
        tests_failed = 0;
        exp_count   = 0;

        $readmemh("test/core_stimulus.txt", stim);
        stim_ok = !$isunknown(stim[0]) && stim[0] != 0 && stim[0] <= IMEM_WORDS
                  && stim[0] + 2 < STIM_DEPTH;
        if (stim_ok) begin
            word_count = stim[0];
            exp_base   = word_count + 2;
            stim_ok    = !$isunknown(stim[word_count + 1]) && stim[word_count + 1] != 0
                         && exp_base + stim[word_count + 1] <= STIM_DEPTH;
        end

        if (!stim_ok) begin
            $display("stimulus file test/core_stimulus.txt is missing or malformed");
            errors++;
        end else begin
            exp_count   = stim[word_count + 1];
            cycle_limit = word_count + 20 * exp_count + 200;
            repeat (4) @(posedge clk);
            rst <= 1'b0;

            errors_before = errors;
            load_program();
            end_test("load handshake", errors_before);

            @(posedge clk);
            run <= 1'b1;
            while (observed.size() < exp_count)
                @(negedge clk);
            // extra cycles so that stray writes show up
            repeat (DRAIN_CYCLES) @(negedge clk);

            errors_before = errors;
            for (int i = 0; i < exp_count && i < observed.size(); i++)
                check_equal(observed[i], stim[exp_base + i], $sformatf("tohost write %0d", i));
            end_test("tohost values", errors_before);

            errors_before = errors;
            check_equal(observed.size(), exp_count, "number of tohost writes");
            end_test("tohost count", errors_before);

            // a word offered while running must wait, so the self-loop stays intact
            loop_idx = 0;
            for (int i = 0; i < word_count; i++) begin
                if (stim[i + 1] == JAL_SELF)
                    loop_idx = i;
            end
            errors_before = errors;
            @(posedge clk);
            load_valid <= 1'b1;
            load_addr  <= 10'(loop_idx);
            load_data  <= CSRWI_ONE;
            repeat (4) begin
                @(negedge clk);
                check_equal(load_ready, 1'b0, "load_ready while running");
            end
            @(posedge clk);
            load_valid <= 1'b0;
            repeat (DRAIN_CYCLES) @(negedge clk);
            check_equal(observed.size(), exp_count, "tohost writes after blocked load");
            end_test("load back-pressure", errors_before);
        end

        $display("%0d tests, %0d failed, %0d mismatches", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- sim.f
hdl/rv_isa_pkg.sv
hdl/rv_ctrl_pkg.sv
hdl/controller.sv
hdl/reg_file.sv
hdl/imm_gen.sv
hdl/exec_unit.sv
hdl/mem_align.sv
hdl/sync_ram.sv
hdl/riscv_core.sv
test/tb_riscv_core.sv

//--- test/core_stimulus.txt
// word 0: program length (hex), then the program words from address 0
// after the program: expected tohost count (hex), then the expected tohost values in order
00000048
00500093 FFD00113 002081B3 51E19073 // 00: addi x1, addi x2, add x3, csrw x3
40208233 51E21073 001122B3 00113333 // 10: sub x4, csrw x4, slt x5, sltu x6
51E29073 51E31073 0F014393 51E39073 // 20: csrw x5, csrw x6, xori x7, csrw x7
40115413 01C15493 51E41073 51E49073 // 30: srai x8, srli x9, csrw x8, csrw x9
00409513 00956533 007575B3 51E59073 // 40: slli x10, or x10, and x11, csrw x11
12345637 00001697 51E61073 51E69073 // 50: lui x12, auipc x13, csrw x12, csrw x13
51EFD073 87654737 3A970713 10E02023 // 60: csrwi 31, lui x14, addi x14, sw x14
10000783 51E79073 10205783 51E79073 // 70: lb x15, csrw x15, lhu x15, csrw x15
101000A3 10201123 10002783 00178793 // 80: sb x1, sh x2, lw x15, addi x15
51E79073 10201783 51E79073 10304783 // 90: csrw x15, lh x15, csrw x15, lbu x15
51E79073 00108463 51EF5073 00209463 // a0: csrw x15, beq taken, csrwi 30, bne taken
51EF5073 00114463 51EF5073 0020D463 // b0: csrwi 30, blt taken, csrwi 30, bge taken
51EF5073 0020E463 51EF5073 00117463 // c0: csrwi 30, bltu taken, csrwi 30, bgeu taken
51EF5073 00208463 51E0D073 00109463 // d0: csrwi 30, beq not taken, csrwi 1, bne not taken
51E15073 0020C463 51E1D073 00115463 // e0: csrwi 2, blt not taken, csrwi 3, bge not taken
51E25073 00116463 51E2D073 0020F463 // f0: csrwi 4, bltu not taken, csrwi 5, bgeu not taken
51E35073 0100086F 51EF5073 51E89073 // 100: csrwi 6, jal x16, csrwi 30, csrw x17
0000006F 51E81073 004808E7 51EF5073 // 110: jal x0 0, csrw x16, jalr x17, csrwi 30
00000018
00000002 00000008 00000001 00000000
FFFFFF0D FFFFFFFE 0000000F 0000000D
12345000 00001054 0000001F FFFFFFA9
00008765 FFFD05AA FFFFFFFD 000000FF
00000001 00000002 00000003 00000004
00000005 00000006 00000108 0000011C
